//--- lsu_align.sv
// Stage 1 of the LSU: registers the request with its byte mask, lane-shifted data and misalign flag
`include "lsu_consts.svh"

module lsu_align
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [`LSU_XLEN-1:0]   i_addr,
  input  logic [`LSU_XLEN-1:0]   i_wdata,
  input  mem_op_e                i_mem_op,
  input  logic                   i_wr_en,
  input  logic                   i_rd_en,
  output logic                   o_wr,
  output logic                   o_rd,
  output logic [7:0]             o_word_idx,
  output logic [`LSU_LANES-1:0]  o_wmask,
  output logic [`LSU_XLEN-1:0]   o_wdata,
  output logic [2:0]             o_offset,
  output mem_op_e                o_op,
  output logic                   o_misalign
);

  logic [2:0]            offset;
  logic [1:0]            size_log2;
  logic [`LSU_LANES-1:0] base_mask;
  logic [`LSU_LANES-1:0] wmask_c;
  logic [`LSU_XLEN-1:0]  wdata_c;
  logic                  misaligned;
  logic                  access;
  logic                  aligned_ok;

  assign offset = i_addr[2:0];

  always_comb begin
    case (i_mem_op)
      OP_B, OP_BU: size_log2 = 2'd0;
      OP_H, OP_HU: size_log2 = 2'd1;
      OP_W, OP_WU: size_log2 = 2'd2;
      default:     size_log2 = 2'd3;  // OP_D; OP_NONE never reaches the strobes
    endcase
  end

  always_comb begin
    case (size_log2)
      2'd0:    base_mask = `LSU_LANES'h01;
      2'd1:    base_mask = `LSU_LANES'h03;
      2'd2:    base_mask = `LSU_LANES'h0f;
      default: base_mask = `LSU_LANES'hff;
    endcase
  end

  // The offset must be a multiple of the access width
  always_comb begin
    case (size_log2)
      2'd0:    misaligned = 1'b0;
      2'd1:    misaligned = offset[0];
      2'd2:    misaligned = |offset[1:0];
      default: misaligned = |offset;
    endcase
  end

  assign wmask_c = base_mask << offset;
  assign wdata_c = i_wdata << {offset, 3'b000};  // Low bytes of the store move up into their lanes

  assign access     = (i_wr_en | i_rd_en) && (i_mem_op != OP_NONE);
  assign aligned_ok = access && !misaligned;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wr       <= 1'b0;
      o_rd       <= 1'b0;
      o_misalign <= 1'b0;
    end else begin
      o_wr       <= aligned_ok & i_wr_en;
      o_rd       <= aligned_ok & ~i_wr_en & i_rd_en;  // A store wins when both enables are set
      o_misalign <= access & misaligned;
    end
  end

  always_ff @(posedge i_clk) begin
    o_word_idx <= i_addr[10:3];  // Upper address bits are dropped, so the RAM wraps
    o_wmask    <= wmask_c;
    o_wdata    <= wdata_c;
    o_offset   <= offset;
    o_op       <= i_mem_op;
  end

endmodule

//--- lsu_checker.sv
// Testbench checker for the LSU: keeps a byte-array memory model and compares the DUT outputs
`include "lsu_consts.svh"

module lsu_checker
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [`LSU_XLEN-1:0]  i_addr,
  input  logic [`LSU_XLEN-1:0]  i_wdata,
  input  logic [2:0]            i_mem_op,
  input  logic                  i_wr_en,
  input  logic                  i_rd_en,
  input  logic                  i_rd_valid,
  input  logic [`LSU_XLEN-1:0]  i_rd_data,
  input  logic                  i_misalign,
  output int                    o_errors,
  output int                    o_loads,
  output int                    o_misaligns,
  output int                    o_pending
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]           model_mem [0:`LSU_RAM_WORDS*`LSU_LANES-1];
  logic [`LSU_XLEN-1:0] exp_q [$];
  int                   due_q [$];
  logic                 exp_mis;
  logic                 armed;
  int                   cycle;
  int                   err_cnt;
  int                   load_cnt;
  int                   mis_cnt;
  int                   pend_cnt;

  assign o_errors    = err_cnt;
  assign o_loads     = load_cnt;
  assign o_misaligns = mis_cnt;
  assign o_pending   = pend_cnt;

  function automatic int access_bytes(mem_op_e op);
    case (op)
      OP_B, OP_BU: return 1;
      OP_H, OP_HU: return 2;
      OP_W, OP_WU: return 4;
      default:     return 8;
    endcase
  endfunction

  // Gathers the addressed bytes little-endian, then fills the upper bytes per operation
  function automatic logic [`LSU_XLEN-1:0] model_load(int base, mem_op_e op);
    logic [`LSU_XLEN-1:0] v;
    int                   n;
    logic                 sign;
    n = access_bytes(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = model_mem[base + i];
    end
    sign = v[8*n-1];
    if (op == OP_B || op == OP_H || op == OP_W) begin
      for (int i = n; i < `LSU_LANES; i++) begin
        v[8*i +: 8] = {8{sign}};
      end
    end
    return v;
  endfunction

  task automatic report_error(string msg);
    err_cnt++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  // Applies the request sampled at this rising edge to the model
  task automatic sample_request();
    mem_op_e op;
    int      nb;
    int      off;
    int      base;
    cycle++;
    exp_mis = 1'b0;
    op = mem_op_e'(i_mem_op);
    if (i_rst) begin
      exp_q.delete();
      due_q.delete();
      armed = 1'b1;
    end else if (armed && (i_wr_en || i_rd_en) && op != OP_NONE) begin
      nb   = access_bytes(op);
      off  = int'(i_addr[2:0]);
      base = int'(i_addr[10:3]) * `LSU_LANES + off;  // Bits above 10 fall away
      if (off % nb != 0) begin
        exp_mis = 1'b1;
      end else if (i_wr_en) begin
        for (int i = 0; i < nb; i++) begin
          model_mem[base + i] = i_wdata[8*i +: 8];
        end
      end else begin
        exp_q.push_back(model_load(base, op));
        due_q.push_back(cycle + 2);
      end
    end
    pend_cnt = due_q.size();
  endtask

  // Outputs are compared at the falling edge, half a cycle after they settle
  task automatic check_outputs();
    if (i_misalign !== exp_mis) begin
      report_error($sformatf("o_misalign is %b, expected %b", i_misalign, exp_mis));
    end else if (exp_mis) begin
      mis_cnt++;
    end
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      if (i_rd_valid !== 1'b1) begin
        report_error($sformatf("o_rd_valid missing, expected data %h", exp_q[0]));
      end else if (i_rd_data !== exp_q[0]) begin
        report_error($sformatf("o_rd_data is %h, expected %h", i_rd_data, exp_q[0]));
      end else begin
        load_cnt++;
      end
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end else if (i_rd_valid !== 1'b0) begin
      report_error($sformatf("o_rd_valid is %b with no load due", i_rd_valid));
    end
    pend_cnt = due_q.size();
  endtask

  initial begin
    armed    = 1'b0;
    exp_mis  = 1'b0;
    cycle    = 0;
    err_cnt  = 0;
    load_cnt = 0;
    mis_cnt  = 0;
    pend_cnt = 0;
    forever begin
      @(posedge i_clk);
      sample_request();
      @(negedge i_clk);
      if (armed) begin
        check_outputs();
      end
    end
  end

endmodule

//--- lsu_consts.svh
// Size constants for the load/store unit, included by the RTL and the testbench
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width of the RV64 data side
`define LSU_XLEN 64

// Byte lanes in one data word
`define LSU_LANES 8

// Data RAM depth in 64-bit words, indexed by address bits 10 to 3
`define LSU_RAM_WORDS 256

`endif

//--- lsu_dram.sv
// Stage 2 of the LSU: byte-masked data RAM that commits stores and registers the word read by loads
`include "lsu_consts.svh"

module lsu_dram
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_wr,
  input  logic                   i_rd,
  input  logic [7:0]             i_word_idx,
  input  logic [`LSU_LANES-1:0]  i_wmask,
  input  logic [`LSU_XLEN-1:0]   i_wdata,
  input  logic [2:0]             i_offset,
  input  mem_op_e                i_op,
  output logic                   o_rd_valid,
  output logic [`LSU_XLEN-1:0]   o_rword,
  output logic [2:0]             o_offset,
  output mem_op_e                o_op
);

  logic [`LSU_XLEN-1:0] mem [0:`LSU_RAM_WORDS-1];

  // Only the lanes selected by the mask are written
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      for (int lane = 0; lane < `LSU_LANES; lane++) begin
        if (i_wmask[lane]) begin
          mem[i_word_idx][8*lane +: 8] <= i_wdata[8*lane +: 8];
        end
      end
    end
  end

  // A store and a load never share this stage, so the read sees every earlier store
  always_ff @(posedge i_clk) begin
    if (i_rd) begin
      o_rword  <= mem[i_word_idx];
      o_offset <= i_offset;
      o_op     <= i_op;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd;
    end
  end

endmodule

//--- lsu_load_ext.sv
// Stage 3 of the LSU: shifts the loaded word down to its offset and extends it per operation
`include "lsu_consts.svh"

module lsu_load_ext
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_rd_valid,
  input  logic [`LSU_XLEN-1:0]  i_rword,
  input  logic [2:0]            i_offset,
  input  mem_op_e               i_op,
  output logic                  o_rd_valid,
  output logic [`LSU_XLEN-1:0]  o_rd_data
);

  logic [`LSU_XLEN-1:0] shifted;
  logic [`LSU_XLEN-1:0] extended;

  assign shifted = i_rword >> {i_offset, 3'b000};  // Addressed byte lands in lane 0

  always_comb begin
    case (i_op)
      OP_B: begin
        extended = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      OP_BU: begin
        extended = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      end
      OP_H: begin
        extended = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      OP_HU: begin
        extended = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      end
      OP_W: begin
        extended = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
      end
      OP_WU: begin
        extended = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
      end
      default: begin
        extended = shifted;  // OP_D takes the whole word
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_valid;
    end
  end

  // Data is held between loads so the output only moves with a valid result
  always_ff @(posedge i_clk) begin
    if (i_rd_valid) begin
      o_rd_data <= extended;
    end
  end

endmodule

//--- lsu_pkg.sv
// Memory-operation type shared by the LSU pipeline stages and the testbench checker
package lsu_pkg;

  // Width codes follow the core's MemOP field; signed and unsigned pairs store alike
  typedef enum logic [2:0] {
    OP_B    = 3'd0,  // Byte, sign-extended on load
    OP_BU   = 3'd1,  // Byte, zero-extended on load
    OP_H    = 3'd2,  // Halfword, sign-extended on load
    OP_HU   = 3'd3,  // Halfword, zero-extended on load
    OP_W    = 3'd4,  // Word, sign-extended on load
    OP_WU   = 3'd5,  // Word, zero-extended on load
    OP_D    = 3'd6,  // Doubleword
    OP_NONE = 3'd7   // No access this cycle
  } mem_op_e;

endpackage

//--- lsu_top.f
+incdir+.
lsu_pkg.sv
lsu_align.sv
lsu_dram.sv
lsu_load_ext.sv
lsu_top.sv
lsu_checker.sv
tb_lsu_top.sv

//--- lsu_top.sv
// LSU top level: chains the align, data RAM and load-extend stages into a three-stage pipeline
`include "lsu_consts.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic [`LSU_XLEN-1:0]  i_addr,
  input  logic [`LSU_XLEN-1:0]  i_wdata,
  input  logic [2:0]            i_mem_op,
  input  logic                  i_wr_en,
  input  logic                  i_rd_en,
  output logic                  o_rd_valid,
  output logic [`LSU_XLEN-1:0]  o_rd_data,
  output logic                  o_misalign
);

  logic                  s1_wr;
  logic                  s1_rd;
  logic [7:0]            s1_word_idx;
  logic [`LSU_LANES-1:0] s1_wmask;
  logic [`LSU_XLEN-1:0]  s1_wdata;
  logic [2:0]            s1_offset;
  mem_op_e               s1_op;

  logic                  s2_rd_valid;
  logic [`LSU_XLEN-1:0]  s2_rword;
  logic [2:0]            s2_offset;
  mem_op_e               s2_op;

  lsu_align u_align (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_mem_op   (mem_op_e'(i_mem_op)),  // Raw 3-bit code from the decoder
    .i_wr_en    (i_wr_en),
    .i_rd_en    (i_rd_en),
    .o_wr       (s1_wr),
    .o_rd       (s1_rd),
    .o_word_idx (s1_word_idx),
    .o_wmask    (s1_wmask),
    .o_wdata    (s1_wdata),
    .o_offset   (s1_offset),
    .o_op       (s1_op),
    .o_misalign (o_misalign)
  );

  lsu_dram u_dram (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr       (s1_wr),
    .i_rd       (s1_rd),
    .i_word_idx (s1_word_idx),
    .i_wmask    (s1_wmask),
    .i_wdata    (s1_wdata),
    .i_offset   (s1_offset),
    .i_op       (s1_op),
    .o_rd_valid (s2_rd_valid),
    .o_rword    (s2_rword),
    .o_offset   (s2_offset),
    .o_op       (s2_op)
  );

  lsu_load_ext u_load_ext (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rd_valid (s2_rd_valid),
    .i_rword    (s2_rword),
    .i_offset   (s2_offset),
    .i_op       (s2_op),
    .o_rd_valid (o_rd_valid),
    .o_rd_data  (o_rd_data)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the LSU testbench with Verilator, runs it into sim.log and exits non-zero on failure
rm -f sim.log
verilator --binary --timescale 1ns/1ps --top-module tb_lsu_top -f lsu_top.f -o sim_lsu \
  && ./obj_dir/sim_lsu > sim.log 2>&1 \
  || echo "Build or simulation run did not complete"
grep -q "^Result: PASSED$" sim.log \
  && echo "Simulation passed, log in sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- tb_lsu_top.sv
// Testbench top for the LSU: clock, reset, seeded random traffic, watchdog and the checker
`include "lsu_consts.svh"

module tb_lsu_top
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int RANDOM_REQS   = 3000;
  localparam int MARGIN_CYCLES = 50;

  logic                 clk;
  logic                 rst;
  logic [`LSU_XLEN-1:0] addr;
  logic [`LSU_XLEN-1:0] wdata;
  logic [2:0]           mem_op;
  logic                 wr_en;
  logic                 rd_en;
  logic                 rd_valid;
  logic [`LSU_XLEN-1:0] rd_data;
  logic                 misalign;
  int                   errors;
  int                   loads;
  int                   misaligns;
  int                   pending;
  integer               seed;
  logic [7:0]           last_idx;

  lsu_top UUT (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_addr     (addr),
    .i_wdata    (wdata),
    .i_mem_op   (mem_op),
    .i_wr_en    (wr_en),
    .i_rd_en    (rd_en),
    .o_rd_valid (rd_valid),
    .o_rd_data  (rd_data),
    .o_misalign (misalign)
  );

  lsu_checker u_checker (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_addr      (addr),
    .i_wdata     (wdata),
    .i_mem_op    (mem_op),
    .i_wr_en     (wr_en),
    .i_rd_en     (rd_en),
    .i_rd_valid  (rd_valid),
    .i_rd_data   (rd_data),
    .i_misalign  (misalign),
    .o_errors    (errors),
    .o_loads     (loads),
    .o_misaligns (misaligns),
    .o_pending   (pending)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CYCLES + `LSU_RAM_WORDS + RANDOM_REQS + MARGIN_CYCLES) * CLK_PERIOD_NS);
    $display("Error: timeout, the test did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  task automatic drive_request(input logic [`LSU_XLEN-1:0] a, input logic [`LSU_XLEN-1:0] d,
                               input logic [2:0] op, input logic wr, input logic rd);
    @(negedge clk);
    addr   = a;
    wdata  = d;
    mem_op = op;
    wr_en  = wr;
    rd_en  = rd;
  endtask

  // One doubleword store per RAM word so every later load reads known data
  task automatic preload_ram();
    logic [`LSU_XLEN-1:0] a;
    logic [`LSU_XLEN-1:0] d;
    for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
      a = '0;
      a[10:3] = w[7:0];
      d = {$random(seed), $random(seed)};
      drive_request(a, d, OP_D, 1'b1, 1'b0);
    end
  endtask

  task automatic random_request();
    logic [31:0]          r;
    logic [`LSU_XLEN-1:0] a;
    logic [`LSU_XLEN-1:0] d;
    r = $random(seed);
    a = {$random(seed), $random(seed)};  // Random upper bits exercise the address wrap
    d = {$random(seed), $random(seed)};
    if (r[1:0] == 2'b00) begin
      a[10:3] = last_idx;  // Reusing the word gives back-to-back store and load hits
    end
    last_idx = a[10:3];
    drive_request(a, d, r[6:4], r[2], r[3]);  // Enables 00 idle, 01 store, 10 load, 11 both
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 0 && n < 8) begin
      @(negedge clk);
      n++;
    end
    repeat (2) @(negedge clk);
    @(posedge clk);
  endtask

  initial begin
    seed     = 32'hcbac02f6;
    last_idx = 8'd0;
    rst      = 1'b1;
    addr     = '0;
    wdata    = '0;
    mem_op   = OP_NONE;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    preload_ram();
    for (int i = 0; i < RANDOM_REQS; i++) begin
      random_request();
    end
    drive_request('0, '0, OP_NONE, 1'b0, 1'b0);
    wait_drain();
    $display("Summary: loads=%0d misaligns=%0d pending=%0d errors=%0d",
             loads, misaligns, pending, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
